/* compile.f */
source/tlp_rx_pkg.sv
source/tlp_stream_if.sv
source/tlp_sync_fifo.sv
source/tlp_packet_buffer.sv
source/tlp_header_decoder.sv
source/tlp_rx_moderator.sv
source/tlp_rx_top.sv
verification/tb_tlp_rx.sv

/* Makefile */
TOP = tb_tlp_rx

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* verification/tb_tlp_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tlp_rx;

	localparam int DATA_DEPTH   = 16;
	localparam int DESC_DEPTH   = 4;
	localparam int MAX_BEATS    = 4;	// packets are 1..4 beats
	localparam int N_MEM        = 20;
	localparam int N_IOCPL      = 24;
	localparam int N_OTHER      = 10;
	localparam int N_RAND       = 60;
	localparam int N_BP         = 12;
	localparam int STALL_CYC    = 40;	// engines held off this long
	localparam int WATCHDOG_CYC =
		(N_MEM + N_IOCPL + N_OTHER + N_RAND + N_BP) * MAX_BEATS * 40 + 1000;

	typedef struct packed {
		logic [1:0]  eng;	// 3 means drained
		logic [2:0]  bar;
		logic [9:0]  len;
	} route_t;

	typedef struct packed {
		logic [1:0]  eng;
		logic        sop;
		logic        eop;
		logic [63:0] data;
		logic [2:0]  bar;
		logic [9:0]  len;
	} exp_beat_t;

	logic        w_AppClk;
	logic        i_rst_n;
	logic        i_rx_valid;
	logic        i_rx_sop;
	logic        i_rx_eop;
	logic [63:0] i_rx_data;
	logic [7:0]  i_rx_bar;
	logic        o_rx_ready;
	logic [2:0]  o_eng_valid;
	logic [2:0]  i_eng_ready;
	logic        o_eng_sop;
	logic        o_eng_eop;
	logic [63:0] o_eng_data;
	logic [2:0]  o_eng_bar;
	logic [9:0]  o_eng_len;
	logic        o_drop;

	exp_beat_t   exp_q[$];	// expected engine beats and drops in arrival order
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          acc_beats = 0;	// accepted input beats since reset
	int          acc_sops = 0;
	logic [31:0] lfsr_state;	// stimulus stream
	logic [31:0] thr_state;	// engine ready throttling stream
	logic [1:0]  ready_mode;	// 0 all ready, 1 all held, 2 random
	logic        bp_done;
	exp_beat_t   cmp_exp;
	logic [1:0]  cmp_eng;
	logic        cmp_ok;

	tlp_rx_top #(
		.DATA_DEPTH (DATA_DEPTH),
		.DESC_DEPTH (DESC_DEPTH)
	) dut (
		.w_AppClk    (w_AppClk),
		.i_rst_n     (i_rst_n),
		.i_rx_valid  (i_rx_valid),
		.i_rx_sop    (i_rx_sop),
		.i_rx_eop    (i_rx_eop),
		.i_rx_data   (i_rx_data),
		.i_rx_bar    (i_rx_bar),
		.o_rx_ready  (o_rx_ready),
		.o_eng_valid (o_eng_valid),
		.i_eng_ready (i_eng_ready),
		.o_eng_sop   (o_eng_sop),
		.o_eng_eop   (o_eng_eop),
		.o_eng_data  (o_eng_data),
		.o_eng_bar   (o_eng_bar),
		.o_eng_len   (o_eng_len),
		.o_drop      (o_drop)
	);

	// right shifting galois lfsr
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);	// one step per bit
			v[i] = lfsr_state[0];
		end
		return v;
	endfunction

	// expected routing from fmt/type, bar hit vector and length
	function automatic route_t expect_route(input logic [63:0] hdr, input logic [7:0] bar);
		route_t r;
		int     i;
		i = 0;
		while (i < 6 && !bar[i])
			i++;
		r.bar = (i == 6) ? 3'd7 : 3'(i);	// bars 6, 7 ignored
		r.len = hdr[9:0];
		case (hdr[28:24])
			tlp_rx_pkg::TYPE_MEM: r.eng = 2'd0;
			tlp_rx_pkg::TYPE_IO:  r.eng = 2'd1;
			tlp_rx_pkg::TYPE_CPL: r.eng = 2'd2;
			default:              r.eng = 2'd3;
		endcase
		return r;
	endfunction

	function automatic logic [4:0] other_type();
		logic [63:0] rnd;
		logic [4:0]  t;
		rnd = rand_bits(3);
		case (rnd[2:0])
			3'd0:    t = 5'd1;	// mrdlk
			3'd1:    t = 5'd4;	// cfg0
			3'd2:    t = 5'd5;	// cfg1
			3'd3:    t = 5'd16;	// msg
			3'd4:    t = 5'd11;	// cpllk
			3'd5:    t = 5'd27;
			3'd6:    t = 5'd19;
			default: t = 5'd20;
		endcase
		return t;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("Error at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic pop_expected(output exp_beat_t e, output logic ok);
		e = '0;
		ok = 1'b0;
		if (exp_q.size() == 0)
		begin
			$display("engine beat or drop at %0d ns with nothing expected", $time);
			errors++;
		end
		else
		begin
			e = exp_q.pop_front();
			ok = 1'b1;
		end
	endtask

	task automatic drive_beat(input logic sop, input logic eop, input logic [63:0] data,
		input logic [7:0] bar);
		@(negedge w_AppClk);
		i_rx_valid = 1'b1;
		i_rx_sop   = sop;
		i_rx_eop   = eop;
		i_rx_data  = data;
		i_rx_bar   = bar;
		@(posedge w_AppClk);
		while (!o_rx_ready)
			@(posedge w_AppClk);	// held until taken
	endtask

	task automatic send_packet(input logic [4:0] typ);
		logic [63:0] hdr;
		logic [63:0] rnd;
		logic [7:0]  bar;
		int          nbeats;
		route_t      r;
		exp_beat_t   e;
		hdr = rand_bits(64);
		rnd = rand_bits(2);
		hdr[30:29] = rnd[1:0];	// fmt picks rd or wr
		hdr[28:24] = typ;
		rnd = rand_bits(8);
		bar = rnd[7:0];
		rnd = rand_bits(2);
		nbeats = 1 + int'(rnd[1:0]);
		r = expect_route(hdr, bar);
		for (int i = 0; i < nbeats; i++)
		begin
			e.eng  = r.eng;
			e.sop  = (i == 0);
			e.eop  = (i == nbeats - 1);
			e.data = (i == 0) ? hdr : rand_bits(64);
			e.bar  = r.bar;
			e.len  = r.len;
			if (r.eng != 2'd3 || e.eop)
				exp_q.push_back(e);	// a drop is one entry per packet
			drive_beat(e.sop, e.eop, e.data, bar);
		end
	endtask

	task automatic report_test(input string name, input int err0);
		tests_run++;
		if (errors == err0)
			$display("test %s: pass", name);
		else
		begin
			tests_failed++;
			$display("test %s: fail, %0d errors", name, errors - err0);
		end
	endtask

	task automatic drain_and_report(input string name, input int err0);
		@(negedge w_AppClk);
		i_rx_valid = 1'b0;
		while (exp_q.size() != 0)
			@(posedge w_AppClk);
		repeat (4) @(posedge w_AppClk);	// catch stray beats
		report_test(name, err0);
	endtask

	// sel picks 0 mem, 1 io or cpl, 2 other, 3 any
	task automatic run_packets(input string name, input int npkt, input int sel,
		input logic [1:0] mode);
		int          err0;
		logic [63:0] rnd;
		logic [4:0]  typ;
		err0 = errors;
		ready_mode = mode;
		for (int p = 0; p < npkt; p++)
		begin
			rnd = rand_bits(2);
			if (sel == 0 || (sel == 3 && rnd[1:0] == 2'd0))
				typ = tlp_rx_pkg::TYPE_MEM;
			else if (sel == 1)
				typ = rnd[0] ? tlp_rx_pkg::TYPE_IO : tlp_rx_pkg::TYPE_CPL;
			else if (sel == 3 && rnd[1:0] == 2'd1)
				typ = tlp_rx_pkg::TYPE_IO;
			else if (sel == 3 && rnd[1:0] == 2'd2)
				typ = tlp_rx_pkg::TYPE_CPL;
			else
				typ = other_type();
			send_packet(typ);
		end
		drain_and_report(name, err0);
	endtask

	task automatic test_reset();
		int err0;
		err0 = errors;
		@(posedge w_AppClk);
		check_value("o_eng_valid", 64'(o_eng_valid), 64'd0);
		check_value("o_drop", 64'(o_drop), 64'd0);
		@(posedge w_AppClk);
		check_value("o_rx_ready", 64'(o_rx_ready), 64'd1);	// up one cycle after release
		check_value("o_eng_valid", 64'(o_eng_valid), 64'd0);
		check_value("o_drop", 64'(o_drop), 64'd0);
		report_test("reset_state", err0);
	endtask

	task automatic test_backpressure();
		int err0;
		int beats0;
		int sops0;
		err0 = errors;
		ready_mode = 2'd1;
		repeat (2) @(posedge w_AppClk);
		beats0 = acc_beats;
		sops0 = acc_sops;
		bp_done = 1'b0;
		fork
			begin
				repeat (N_BP) send_packet(tlp_rx_pkg::TYPE_MEM);
				bp_done = 1'b1;
			end
		join_none
		repeat (STALL_CYC) @(posedge w_AppClk);
		check_value("o_rx_ready", 64'(o_rx_ready), 64'd0);
		check_value("beats within DATA_DEPTH", 64'(acc_beats - beats0 <= DATA_DEPTH), 64'd1);
		check_value("starts within DESC_DEPTH", 64'(acc_sops - sops0 <= DESC_DEPTH), 64'd1);
		ready_mode = 2'd0;	// release engines
		wait (bp_done);
		drain_and_report("backpressure", err0);
	endtask

	initial
	begin
		w_AppClk = 1'b0;
		forever #10 w_AppClk = ~w_AppClk;	// 50 MHz
	end

	// engine ready changes on the falling edge
	initial
	begin
		thr_state = 32'd71255;
		i_eng_ready = '1;
		forever
		begin
			@(negedge w_AppClk);
			case (ready_mode)
				2'd0:    i_eng_ready = '1;
				2'd1:    i_eng_ready = '0;
				default:
				begin
					for (int i = 0; i < 3; i++)
					begin
						thr_state = lfsr_next(thr_state);
						i_eng_ready[i] = thr_state[0];
					end
				end
			endcase
		end
	end

	always @(posedge w_AppClk)
	begin
		if (i_rst_n && i_rx_valid && o_rx_ready)
		begin
			acc_beats++;
			if (i_rx_sop)
				acc_sops++;
		end
	end

	always @(posedge w_AppClk)
	begin
		if (i_rst_n)
		begin
			if ($countones(o_eng_valid) > 1)
			begin
				$display("more than one engine valid at %0d ns", $time);
				errors++;
			end
			if ((|(o_eng_valid & i_eng_ready)) || o_drop)
			begin
				pop_expected(cmp_exp, cmp_ok);
				if (cmp_ok && o_drop)
					check_value("o_drop target", 64'd3, 64'(cmp_exp.eng));
				else if (cmp_ok)
				begin
					cmp_eng = o_eng_valid[0] ? 2'd0 : (o_eng_valid[1] ? 2'd1 : 2'd2);
					check_value("o_eng_valid engine", 64'(cmp_eng), 64'(cmp_exp.eng));
					check_value("o_eng_sop", 64'(o_eng_sop), 64'(cmp_exp.sop));
					check_value("o_eng_eop", 64'(o_eng_eop), 64'(cmp_exp.eop));
					check_value("o_eng_data", o_eng_data, cmp_exp.data);
					check_value("o_eng_bar", 64'(o_eng_bar), 64'(cmp_exp.bar));
					check_value("o_eng_len", 64'(o_eng_len), 64'(cmp_exp.len));
				end
			end
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYC) @(posedge w_AppClk);
		$display("timeout: traffic did not finish within %0d cycles", WATCHDOG_CYC);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		lfsr_state = 32'd71255;
		ready_mode = 2'd0;
		bp_done    = 1'b0;
		i_rst_n    = 1'b0;
		i_rx_valid = 1'b0;
		i_rx_sop   = 1'b0;
		i_rx_eop   = 1'b0;
		i_rx_data  = '0;
		i_rx_bar   = '0;
		repeat (10) @(posedge w_AppClk);
		@(negedge w_AppClk);
		i_rst_n = 1'b1;
		test_reset();
		run_packets("mem_routing", N_MEM, 0, 2'd0);
		run_packets("io_cpl_routing", N_IOCPL, 1, 2'd0);
		run_packets("other_drop", N_OTHER, 2, 2'd0);
		run_packets("random_throttle", N_RAND, 3, 2'd2);
		test_backpressure();
		if (exp_q.size() != 0)
		begin
			$display("%0d expected beats never reached an engine", exp_q.size());
			errors++;
		end
		$display("tests %0d  passed %0d  failed %0d  errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* source/tlp_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tlp_rx_top #(
	parameter int DATA_DEPTH = 16,	// buffered beats
	parameter int DESC_DEPTH = 4	// buffered headers
) (
	input  wire                                w_AppClk,
	input  wire                                i_rst_n,
	input  wire                                i_rx_valid,
	input  wire                                i_rx_sop,
	input  wire                                i_rx_eop,
	input  wire  [tlp_rx_pkg::DATA_W-1:0]      i_rx_data,
	input  wire  [tlp_rx_pkg::BAR_W-1:0]       i_rx_bar,
	output logic                               o_rx_ready,
	output logic [tlp_rx_pkg::NUM_ENG-1:0]     o_eng_valid,
	input  wire  [tlp_rx_pkg::NUM_ENG-1:0]     i_eng_ready,
	output logic                               o_eng_sop,
	output logic                               o_eng_eop,
	output logic [tlp_rx_pkg::DATA_W-1:0]      o_eng_data,
	output logic [tlp_rx_pkg::BAR_IDX_W-1:0]   o_eng_bar,
	output logic [tlp_rx_pkg::LEN_W-1:0]       o_eng_len,
	output logic                               o_drop
);

	logic                   w_accept;	// beat taken from hard ip
	logic                   w_desc_room;
	logic                   w_desc_valid;
	logic                   w_desc_pop;
	tlp_rx_pkg::tlp_desc_t  w_desc;

	tlp_stream_if u_buf_stream ();	// buffer -> moderator

	tlp_packet_buffer #(
		.DATA_DEPTH (DATA_DEPTH)
	) u_packet_buffer (
		.w_AppClk    (w_AppClk),
		.i_rst_n     (i_rst_n),
		.i_rx_valid  (i_rx_valid),
		.i_rx_sop    (i_rx_sop),
		.i_rx_eop    (i_rx_eop),
		.i_rx_data   (i_rx_data),
		.i_desc_room (w_desc_room),
		.o_rx_ready  (o_rx_ready),
		.o_accept    (w_accept),
		.o_stream    (u_buf_stream.src)
	);

	// sees the same beats as the buffer
	tlp_header_decoder #(
		.DESC_DEPTH (DESC_DEPTH)
	) u_header_decoder (
		.w_AppClk     (w_AppClk),
		.i_rst_n      (i_rst_n),
		.i_accept     (w_accept),
		.i_rx_sop     (i_rx_sop),
		.i_rx_data    (i_rx_data),
		.i_rx_bar     (i_rx_bar),
		.o_desc_room  (w_desc_room),
		.o_desc_valid (w_desc_valid),
		.o_desc       (w_desc),
		.i_desc_pop   (w_desc_pop)
	);

	tlp_rx_moderator u_rx_moderator (
		.w_AppClk     (w_AppClk),
		.i_rst_n      (i_rst_n),
		.i_stream     (u_buf_stream.dst),
		.i_desc_valid (w_desc_valid),
		.i_desc       (w_desc),
		.o_desc_pop   (w_desc_pop),
		.o_eng_valid  (o_eng_valid),
		.i_eng_ready  (i_eng_ready),
		.o_eng_sop    (o_eng_sop),
		.o_eng_eop    (o_eng_eop),
		.o_eng_data   (o_eng_data),
		.o_eng_bar    (o_eng_bar),
		.o_eng_len    (o_eng_len),
		.o_drop       (o_drop)
	);

endmodule

`default_nettype wire

/* source/tlp_rx_moderator.sv */
`timescale 1ns/1ps
`default_nettype none

module tlp_rx_moderator (
	input  wire                                w_AppClk,
	input  wire                                i_rst_n,
	tlp_stream_if.dst                          i_stream,	// buffered beats
	input  wire                                i_desc_valid,
	input  wire tlp_rx_pkg::tlp_desc_t         i_desc,
	output logic                               o_desc_pop,	// with the end beat
	output logic [tlp_rx_pkg::NUM_ENG-1:0]     o_eng_valid,
	input  wire  [tlp_rx_pkg::NUM_ENG-1:0]     i_eng_ready,
	output logic                               o_eng_sop,
	output logic                               o_eng_eop,
	output logic [tlp_rx_pkg::DATA_W-1:0]      o_eng_data,
	output logic [tlp_rx_pkg::BAR_IDX_W-1:0]   o_eng_bar,
	output logic [tlp_rx_pkg::LEN_W-1:0]       o_eng_len,
	output logic                               o_drop	// unsupported tlp drained
);

	typedef enum logic [1:0] {
		ST_IDLE,	// wait for header + start beat
		ST_ROUTE,	// forward to r_sel engine
		ST_DRAIN	// discard packet
	} state_t;

	state_t                             r_state;
	state_t                             w_state_nxt;
	logic [tlp_rx_pkg::NUM_ENG-1:0]     r_sel;		// one-hot engine enable
	logic [tlp_rx_pkg::NUM_ENG-1:0]     w_sel_nxt;
	logic [tlp_rx_pkg::BAR_IDX_W-1:0]   r_bar;
	logic [tlp_rx_pkg::LEN_W-1:0]       r_len;
	logic                               w_start;
	logic                               w_xfer;
	logic                               w_last;

	assign w_start = (r_state == ST_IDLE) & i_desc_valid & i_stream.valid & i_stream.sop;
	assign w_xfer  = i_stream.valid & i_stream.ready;
	assign w_last  = w_xfer & i_stream.eop;

	// class -> engine
	always_comb
	begin
		case (i_desc.cls)
			tlp_rx_pkg::MEM_RD, tlp_rx_pkg::MEM_WR: w_sel_nxt = 3'b001;
			tlp_rx_pkg::IO_RD,  tlp_rx_pkg::IO_WR:  w_sel_nxt = 3'b010;
			tlp_rx_pkg::CPL,    tlp_rx_pkg::CPL_D:  w_sel_nxt = 3'b100;
			default:                                w_sel_nxt = '0;	// drop
		endcase
	end

	always_comb
	begin
		w_state_nxt = r_state;
		case (r_state)
			ST_IDLE:
			begin
				if (w_start)
					w_state_nxt = (w_sel_nxt == '0) ? ST_DRAIN : ST_ROUTE;
			end
			ST_ROUTE, ST_DRAIN:
			begin
				if (w_last)
					w_state_nxt = ST_IDLE;	// packet done
			end
			default:
				w_state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge w_AppClk)
	begin
		if (!i_rst_n)
		begin
			r_state <= ST_IDLE;
			r_sel   <= '0;
		end
		else
		begin
			r_state <= w_state_nxt;
			if (w_start)
				r_sel <= w_sel_nxt;	// held for the whole packet
		end
	end

	// sideband for the engine
	always_ff @(posedge w_AppClk)
	begin
		if (w_start)
		begin
			r_bar <= i_desc.bar;
			r_len <= i_desc.len;
		end
	end

	// buffer moves only with the chosen engine and freely in drain
	assign i_stream.ready = (r_state == ST_DRAIN) |
		((r_state == ST_ROUTE) & (|(r_sel & i_eng_ready)));

	assign o_eng_valid = ((r_state == ST_ROUTE) && i_stream.valid) ? r_sel : '0;
	assign o_eng_sop   = i_stream.sop;
	assign o_eng_eop   = i_stream.eop;
	assign o_eng_data  = i_stream.data;
	assign o_eng_bar   = r_bar;
	assign o_eng_len   = r_len;

	assign o_desc_pop = w_last;	// ready is low in idle
	assign o_drop     = (r_state == ST_DRAIN) & w_last;

	// idle always faces a packet start, so no packet boundary got lost
	a_start_in_idle: assert property (@(posedge w_AppClk) disable iff (!i_rst_n)
		(r_state == ST_IDLE) && i_stream.valid |-> i_stream.sop)
		else $error("tlp_rx_moderator: idle with a non-start beat at head");

	// decoder queues the header on the same edge the buffer stores the beat
	a_desc_with_sop: assert property (@(posedge w_AppClk) disable iff (!i_rst_n)
		(r_state == ST_IDLE) && i_stream.valid && i_stream.sop |-> i_desc_valid)
		else $error("tlp_rx_moderator: start beat buffered without descriptor");

endmodule

`default_nettype wire

/* source/tlp_header_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module tlp_header_decoder #(
	parameter int DESC_DEPTH = 4	// packets in flight
) (
	input  wire                            w_AppClk,
	input  wire                            i_rst_n,
	input  wire                            i_accept,	// beat taken by buffer
	input  wire                            i_rx_sop,
	input  wire [tlp_rx_pkg::DATA_W-1:0]   i_rx_data,
	input  wire [tlp_rx_pkg::BAR_W-1:0]    i_rx_bar,
	output logic                           o_desc_room,
	output logic                           o_desc_valid,
	output tlp_rx_pkg::tlp_desc_t          o_desc,	// head descriptor
	input  wire                            i_desc_pop
);

	localparam int BAR_CNT = 6;	// type 0 header, bars 0..5

	logic [tlp_rx_pkg::HDR_FMT_W-1:0]   w_fmt;
	logic [tlp_rx_pkg::HDR_TYPE_W-1:0]  w_type;
	tlp_rx_pkg::tlp_class_t             w_class;
	logic [tlp_rx_pkg::BAR_IDX_W-1:0]   w_bar_idx;
	tlp_rx_pkg::tlp_desc_t              w_desc_new;
	logic                               w_push;
	logic                               w_empty;
	logic                               w_full;

	// dw0 sits in the low word of the start beat
	assign w_fmt  = i_rx_data[tlp_rx_pkg::HDR_FMT_LSB +: tlp_rx_pkg::HDR_FMT_W];
	assign w_type = i_rx_data[tlp_rx_pkg::HDR_TYPE_LSB +: tlp_rx_pkg::HDR_TYPE_W];

	// fmt[1] set means payload follows, i.e. write / cpld
	always_comb
	begin
		case (w_type)
			tlp_rx_pkg::TYPE_MEM:
				w_class = w_fmt[1] ? tlp_rx_pkg::MEM_WR : tlp_rx_pkg::MEM_RD;
			tlp_rx_pkg::TYPE_IO:
				w_class = w_fmt[1] ? tlp_rx_pkg::IO_WR : tlp_rx_pkg::IO_RD;
			tlp_rx_pkg::TYPE_CPL:
				w_class = w_fmt[1] ? tlp_rx_pkg::CPL_D : tlp_rx_pkg::CPL;
			default:
				w_class = tlp_rx_pkg::OTHER;	// msg, cfg, locked ...
		endcase
	end

	// lowest hit bar wins
	always_comb
	begin
		w_bar_idx = tlp_rx_pkg::BAR_NONE;
		for (int i = BAR_CNT - 1; i >= 0; i--)
		begin
			if (i_rx_bar[i])
				w_bar_idx = tlp_rx_pkg::BAR_IDX_W'(i);
		end
	end

	assign w_desc_new.cls = w_class;
	assign w_desc_new.bar = w_bar_idx;
	assign w_desc_new.len = i_rx_data[tlp_rx_pkg::LEN_W-1:0];	// raw length field

	assign w_push = i_accept & i_rx_sop;	// one descriptor per packet

	tlp_sync_fifo #(
		.T     (tlp_rx_pkg::tlp_desc_t),
		.DEPTH (DESC_DEPTH)
	) u_desc_fifo (
		.w_AppClk (w_AppClk),
		.i_rst_n  (i_rst_n),
		.i_wr     (w_push),
		.i_wdata  (w_desc_new),
		.i_rd     (i_desc_pop),
		.o_rdata  (o_desc),
		.o_empty  (w_empty),
		.o_full   (w_full)
	);

	assign o_desc_valid = ~w_empty;	// one cycle after the start beat
	assign o_desc_room  = ~w_full;

endmodule

`default_nettype wire

/* source/tlp_packet_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tlp_packet_buffer #(
	parameter int DATA_DEPTH = 16	// beats
) (
	input  wire                            w_AppClk,
	input  wire                            i_rst_n,
	input  wire                            i_rx_valid,	// from hard ip rx_st
	input  wire                            i_rx_sop,
	input  wire                            i_rx_eop,
	input  wire [tlp_rx_pkg::DATA_W-1:0]   i_rx_data,
	input  wire                            i_desc_room,	// decoder can take a header
	output logic                           o_rx_ready,
	output logic                           o_accept,	// beat taken this cycle
	tlp_stream_if.src                      o_stream
);

	logic                   r_run;		// low in reset, high from first cycle after
	tlp_rx_pkg::tlp_beat_t  w_wbeat;
	tlp_rx_pkg::tlp_beat_t  w_head;
	logic                   w_empty;
	logic                   w_full;
	logic                   w_pop;

	always_ff @(posedge w_AppClk)
	begin
		if (!i_rst_n)
			r_run <= 1'b0;
		else
			r_run <= 1'b1;
	end

	// single acceptance point for the whole rx path
	assign o_rx_ready = r_run & ~w_full & i_desc_room;
	assign o_accept   = i_rx_valid & o_rx_ready;

	assign w_wbeat.sop  = i_rx_sop;
	assign w_wbeat.eop  = i_rx_eop;
	assign w_wbeat.data = i_rx_data;

	assign w_pop = o_stream.valid & o_stream.ready;	// moderator takes head

	tlp_sync_fifo #(
		.T     (tlp_rx_pkg::tlp_beat_t),
		.DEPTH (DATA_DEPTH)
	) u_beat_fifo (
		.w_AppClk (w_AppClk),
		.i_rst_n  (i_rst_n),
		.i_wr     (o_accept),
		.i_wdata  (w_wbeat),
		.i_rd     (w_pop),
		.o_rdata  (w_head),
		.o_empty  (w_empty),
		.o_full   (w_full)
	);

	// head beat straight onto the stream
	assign o_stream.valid = ~w_empty;
	assign o_stream.sop   = w_head.sop;
	assign o_stream.eop   = w_head.eop;
	assign o_stream.data  = w_head.data;

endmodule

`default_nettype wire

/* source/tlp_sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module tlp_sync_fifo #(
	parameter type T     = logic [7:0],	// payload
	parameter int  DEPTH = 4		// entries
) (
	input  wire  w_AppClk,
	input  wire  i_rst_n,
	input  wire  i_wr,		// push, must not be full
	input  wire T i_wdata,
	input  wire  i_rd,		// pop head, must not be empty
	output T     o_rdata,		// head, shown ahead
	output logic o_empty,
	output logic o_full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;	// pointer width
	localparam int CW = $clog2(DEPTH + 1);			// count width

	T               r_mem [DEPTH];
	logic [AW-1:0]  r_wr_ptr;
	logic [AW-1:0]  r_rd_ptr;
	logic [CW-1:0]  r_count;

	// wrap at DEPTH, so non power of two depths work
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge w_AppClk)
	begin
		if (i_wr)
			r_mem[r_wr_ptr] <= i_wdata;	// storage only
	end

	always_ff @(posedge w_AppClk)
	begin
		if (!i_rst_n)
		begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
			r_count  <= '0;
		end
		else
		begin
			if (i_wr)
				r_wr_ptr <= ptr_inc(r_wr_ptr);
			if (i_rd)
				r_rd_ptr <= ptr_inc(r_rd_ptr);
			case ({i_wr, i_rd})
				2'b10:   r_count <= r_count + 1'b1;
				2'b01:   r_count <= r_count - 1'b1;
				default: r_count <= r_count;	// idle or push+pop
			endcase
		end
	end

	assign o_rdata = r_mem[r_rd_ptr];	// head visible one cycle after push
	assign o_empty = (r_count == '0);
	assign o_full  = (r_count == CW'(DEPTH));

	// the owner of i_wr / i_rd must respect the flags
	a_no_overflow: assert property (@(posedge w_AppClk) disable iff (!i_rst_n)
		i_wr |-> !o_full)
		else $error("tlp_sync_fifo: push while full");

	a_no_underflow: assert property (@(posedge w_AppClk) disable iff (!i_rst_n)
		i_rd |-> !o_empty)
		else $error("tlp_sync_fifo: pop while empty");

endmodule

`default_nettype wire

/* source/tlp_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

// buffered beat stream, packet buffer -> moderator
interface tlp_stream_if;

	logic                           valid;	// head beat present
	logic                           sop;	// start of tlp
	logic                           eop;	// end of tlp
	logic [tlp_rx_pkg::DATA_W-1:0]  data;
	logic                           ready;	// moderator takes head beat

	modport src (
		output valid,
		output sop,
		output eop,
		output data,
		input  ready
	);

	modport dst (
		input  valid,
		input  sop,
		input  eop,
		input  data,
		output ready
	);

endinterface

`default_nettype wire

/* source/tlp_rx_pkg.sv */
`default_nettype none

package tlp_rx_pkg;

	localparam int DATA_W    = 64;	// avalon-st data bus from the hard ip
	localparam int BAR_W     = 8;	// rx_st_bar hit vector
	localparam int BAR_IDX_W = 3;	// encoded bar number
	localparam int LEN_W     = 10;	// dword length field
	localparam int NUM_ENG   = 3;	// mem, io, completion engines

	localparam int HDR_FMT_LSB  = 29;	// fmt[1:0] at dw0[30:29]
	localparam int HDR_FMT_W    = 2;
	localparam int HDR_TYPE_LSB = 24;	// type[4:0] at dw0[28:24]
	localparam int HDR_TYPE_W   = 5;

	localparam logic [HDR_TYPE_W-1:0] TYPE_MEM = 5'd0;	// mrd / mwr
	localparam logic [HDR_TYPE_W-1:0] TYPE_IO  = 5'd2;	// iord / iowr
	localparam logic [HDR_TYPE_W-1:0] TYPE_CPL = 5'd10;	// cpl / cpld

	localparam logic [BAR_IDX_W-1:0] BAR_NONE = 3'd7;	// no bar 0..5 hit

	typedef enum logic [2:0] {
		MEM_RD,
		MEM_WR,
		IO_RD,
		IO_WR,
		CPL,	// completion, no payload
		CPL_D,	// completion with data
		OTHER	// msg, cfg, atomics ... all drained
	} tlp_class_t;

	// 16-bit descriptor, one per packet
	typedef struct packed {
		tlp_class_t             cls;
		logic [BAR_IDX_W-1:0]   bar;
		logic [LEN_W-1:0]       len;
	} tlp_desc_t;

	// 66-bit buffered beat
	typedef struct packed {
		logic                   sop;
		logic                   eop;
		logic [DATA_W-1:0]      data;
	} tlp_beat_t;

endpackage

`default_nettype wire
